// ==== lsu_mem.f ====
rtl/lsu_pkg.sv
rtl/dual_port_byte_ram.sv
rtl/lsu_decode.sv
rtl/lsu_execute.sv
rtl/lsu_result.sv
rtl/lsu_mem_top.sv
verif/lsu_mem_props.sv
verif/lsu_mem_tb.sv

// ==== rtl/dual_port_byte_ram.sv ====
`default_nettype none

// behavioral stand-in for the byte-writable block RAM
// one array per byte lane, each lane written under its own enable
module dual_port_byte_ram #(
	parameter int unsigned SIZE = 1024 // depth in words
) (
	input  logic                              clk,
	input  logic                              rst,
	input  logic                              wea,
	input  logic                              web,
	input  logic [lsu_pkg::WORD_BYTES-1:0]    byteenablea,
	input  logic [lsu_pkg::WORD_BYTES-1:0]    byteenableb,
	input  logic [$clog2(SIZE)-1:0]           addra,
	input  logic [$clog2(SIZE)-1:0]           addrb,
	input  logic [lsu_pkg::WORD_WIDTH-1:0]    dina,
	input  logic [lsu_pkg::WORD_WIDTH-1:0]    dinb,
	output logic [lsu_pkg::WORD_WIDTH-1:0]    douta,
	output logic [lsu_pkg::WORD_WIDTH-1:0]    doutb
);

	for (genvar i = 0; i < lsu_pkg::WORD_BYTES; i++) begin : gen_lane
		logic [7:0] lane_mem [SIZE];
		logic       we_a;
		logic       we_b;

		assign we_a = wea & byteenablea[i];
		assign we_b = web & byteenableb[i];

		// contents survive reset
		always_ff @(posedge clk) begin
			if (we_a)
				lane_mem[addra] <= dina[i*8 +: 8];
			if (we_b)
				lane_mem[addrb] <= dinb[i*8 +: 8]; // b wins a same-address clash
		end

		// one cycle read, new data on a write (write-first)
		always_ff @(posedge clk) begin
			if (rst) begin
				douta[i*8 +: 8] <= '0;
				doutb[i*8 +: 8] <= '0;
			end else begin
				douta[i*8 +: 8] <= we_a ? dina[i*8 +: 8] : lane_mem[addra];
				doutb[i*8 +: 8] <= we_b ? dinb[i*8 +: 8] : lane_mem[addrb];
			end
		end
	end

endmodule

`default_nettype wire

// ==== rtl/lsu_decode.sv ====
`default_nettype none

// classifies a data request: size, sign and legality
module lsu_decode (
	input  logic [2:0] funct3,
	input  logic       store,
	input  logic [1:0] addr_low,     // byte offset within the word
	output logic [1:0] acc_size,
	output logic       acc_unsigned,
	output logic       acc_ok,
	output logic       acc_misaligned
);

	logic code_ok;

	always_comb begin
		code_ok      = 1'b1;
		acc_unsigned = 1'b0;
		acc_size     = lsu_pkg::SIZE_BYTE;
		case (funct3)
			lsu_pkg::FUNCT3_B: acc_size = lsu_pkg::SIZE_BYTE;
			lsu_pkg::FUNCT3_H: acc_size = lsu_pkg::SIZE_HALF;
			lsu_pkg::FUNCT3_W: acc_size = lsu_pkg::SIZE_WORD;
			lsu_pkg::FUNCT3_BU: begin
				acc_size     = lsu_pkg::SIZE_BYTE;
				acc_unsigned = 1'b1;
			end
			lsu_pkg::FUNCT3_HU: begin
				acc_size     = lsu_pkg::SIZE_HALF;
				acc_unsigned = 1'b1;
			end
			default: code_ok = 1'b0; // 3, 6 and 7 are reserved
		endcase
	end

	// natural alignment only
	always_comb begin
		case (acc_size)
			lsu_pkg::SIZE_HALF: acc_misaligned = addr_low[0];
			lsu_pkg::SIZE_WORD: acc_misaligned = |addr_low;
			default:            acc_misaligned = 1'b0;
		endcase
		if (!code_ok)
			acc_misaligned = 1'b0; // the bad code is reported instead
	end

	// the one legality verdict for the whole LSU
	// no unsigned flavour exists for stores
	assign acc_ok = code_ok & ~acc_misaligned & ~(store & acc_unsigned);

endmodule

`default_nettype wire

// ==== rtl/lsu_execute.sv ====
`default_nettype none

// drives RAM port B: word address, byte enables, steered write data
module lsu_execute #(
	parameter int unsigned SIZE = 1024 // depth in words
) (
	input  logic                              req_valid,
	input  logic                              req_store,
	input  logic                              acc_ok,
	input  logic [1:0]                        acc_size,
	input  logic [31:0]                       req_addr,
	input  logic [lsu_pkg::WORD_WIDTH-1:0]    req_wdata,
	output logic                              web,
	output logic [lsu_pkg::WORD_BYTES-1:0]    byteenableb,
	output logic [$clog2(SIZE)-1:0]           addrb,
	output logic [lsu_pkg::WORD_WIDTH-1:0]    dinb
);

	localparam int unsigned OFS = lsu_pkg::BYTE_OFFSET_BITS;

	logic [OFS-1:0]     byte_ofs;
	lsu_pkg::mem_word_u wdata_u;

	assign byte_ofs = req_addr[OFS-1:0];
	assign addrb    = req_addr[OFS +: $clog2(SIZE)]; // upper bits wrap
	assign web      = req_valid & req_store & acc_ok;

	always_comb begin
		case (acc_size)
			lsu_pkg::SIZE_BYTE:
				byteenableb = {{(lsu_pkg::WORD_BYTES-1){1'b0}}, 1'b1} << byte_ofs;
			lsu_pkg::SIZE_HALF:
				byteenableb = {{(lsu_pkg::WORD_BYTES-2){1'b0}}, 2'b11} << byte_ofs;
			lsu_pkg::SIZE_WORD:
				byteenableb = '1;
			default:
				byteenableb = '0;
		endcase
	end

	// copy the store data into every lane, the enables pick the right one
	always_comb begin
		wdata_u.bytes = req_wdata;
		for (int i = 0; i < lsu_pkg::WORD_BYTES; i++) begin
			if (acc_size == lsu_pkg::SIZE_BYTE)
				wdata_u.bytes[i] = req_wdata[7:0];
			else if (acc_size == lsu_pkg::SIZE_HALF)
				wdata_u.bytes[i] = req_wdata[(i % 2)*8 +: 8];
		end
	end

	assign dinb = wdata_u;

endmodule

`default_nettype wire

// ==== rtl/lsu_mem_top.sv ====
`default_nettype none

// load/store memory: fetch on RAM port A, data accesses on port B
module lsu_mem_top #(
	parameter int unsigned SIZE = 1024 // depth in words
) (
	input  logic                              clk,
	input  logic                              rst,
	input  logic                              fetch_en,
	input  logic [31:0]                       fetch_addr,   // low bits ignored
	input  logic                              req_valid,
	input  logic                              req_store,
	input  logic [2:0]                        req_funct3,
	input  logic [31:0]                       req_addr,
	input  logic [lsu_pkg::WORD_WIDTH-1:0]    req_wdata,
	output logic                              fetch_valid,
	output logic [lsu_pkg::WORD_WIDTH-1:0]    fetch_data,
	output logic                              load_valid,
	output logic [lsu_pkg::WORD_WIDTH-1:0]    load_data,
	output logic                              store_done,
	output logic                              error
);

	localparam int unsigned OFS = lsu_pkg::BYTE_OFFSET_BITS;

	logic [1:0]                        acc_size;
	logic                              acc_unsigned;
	logic                              acc_ok;
	logic                              web;
	logic [lsu_pkg::WORD_BYTES-1:0]    byteenableb;
	logic [$clog2(SIZE)-1:0]           addra;
	logic [$clog2(SIZE)-1:0]           addrb;
	logic [lsu_pkg::WORD_WIDTH-1:0]    dinb;
	logic [lsu_pkg::WORD_WIDTH-1:0]    doutb;

	assign addra = fetch_addr[OFS +: $clog2(SIZE)];

	// fetch answer lines up with the RAM read latency
	always_ff @(posedge clk) begin
		if (rst)
			fetch_valid <= 1'b0;
		else
			fetch_valid <= fetch_en;
	end

	lsu_decode decode_i (
		.funct3         (req_funct3),
		.store          (req_store),
		.addr_low       (req_addr[1:0]),
		.acc_size       (acc_size),
		.acc_unsigned   (acc_unsigned),
		.acc_ok         (acc_ok),
		.acc_misaligned ()
	);

	lsu_execute #(.SIZE(SIZE)) execute_i (
		.req_valid   (req_valid),
		.req_store   (req_store),
		.acc_ok      (acc_ok),
		.acc_size    (acc_size),
		.req_addr    (req_addr),
		.req_wdata   (req_wdata),
		.web         (web),
		.byteenableb (byteenableb),
		.addrb       (addrb),
		.dinb        (dinb)
	);

	dual_port_byte_ram #(.SIZE(SIZE)) ram_i (
		.clk         (clk),
		.rst         (rst),
		.wea         (1'b0),        // fetch port is read only
		.web         (web),
		.byteenablea ('0),
		.byteenableb (byteenableb),
		.addra       (addra),
		.addrb       (addrb),
		.dina        ('0),
		.dinb        (dinb),
		.douta       (fetch_data),
		.doutb       (doutb)
	);

	lsu_result result_i (
		.clk          (clk),
		.rst          (rst),
		.req_valid    (req_valid),
		.req_store    (req_store),
		.acc_ok       (acc_ok),
		.acc_size     (acc_size),
		.acc_unsigned (acc_unsigned),
		.addr_low     (req_addr[OFS-1:0]),
		.doutb        (doutb),
		.load_valid   (load_valid),
		.load_data    (load_data),
		.store_done   (store_done),
		.error        (error)
	);

endmodule

`default_nettype wire

// ==== rtl/lsu_pkg.sv ====
`default_nettype none

package lsu_pkg;

	// word geometry of the data RAM
	localparam int unsigned WORD_BYTES = 4;
	localparam int unsigned WORD_WIDTH = WORD_BYTES * 8;

	// bits of a byte address that select a lane inside a word
	localparam int unsigned BYTE_OFFSET_BITS = $clog2(WORD_BYTES);

	// RV32I load/store width field (funct3)
	localparam logic [2:0] FUNCT3_B  = 3'b000;
	localparam logic [2:0] FUNCT3_H  = 3'b001;
	localparam logic [2:0] FUNCT3_W  = 3'b010;
	localparam logic [2:0] FUNCT3_BU = 3'b100;
	localparam logic [2:0] FUNCT3_HU = 3'b101;

	// access size as seen by execute and result
	localparam logic [1:0] SIZE_BYTE = 2'd0;
	localparam logic [1:0] SIZE_HALF = 2'd1;
	localparam logic [1:0] SIZE_WORD = 2'd2;

	// one RAM word, viewed as byte lanes or as halfword lanes
	// lane 0 holds the least significant bits in both views
	typedef union packed {
		logic [WORD_BYTES-1:0][7:0]    bytes;
		logic [WORD_BYTES/2-1:0][15:0] halves;
	} mem_word_u;

endpackage

`default_nettype wire

// ==== rtl/lsu_result.sv ====
`default_nettype none

// second stage of a data access: lane extraction and completion strobes
module lsu_result (
	input  logic                                    clk,
	input  logic                                    rst,
	input  logic                                    req_valid,
	input  logic                                    req_store,
	input  logic                                    acc_ok,
	input  logic [1:0]                              acc_size,
	input  logic                                    acc_unsigned,
	input  logic [lsu_pkg::BYTE_OFFSET_BITS-1:0]    addr_low,
	input  logic [lsu_pkg::WORD_WIDTH-1:0]          doutb,
	output logic                                    load_valid,
	output logic [lsu_pkg::WORD_WIDTH-1:0]          load_data,
	output logic                                    store_done,
	output logic                                    error
);

	localparam int unsigned OFS = lsu_pkg::BYTE_OFFSET_BITS;

	// context of the access whose RAM data arrives this cycle
	logic           valid_q;
	logic           store_q;
	logic           ok_q;
	logic [1:0]     size_q;
	logic           unsigned_q;
	logic [OFS-1:0] ofs_q;

	lsu_pkg::mem_word_u word_u;
	logic [7:0]         byte_lane;
	logic [15:0]        half_lane;

	always_ff @(posedge clk) begin
		if (rst) begin
			valid_q <= 1'b0;
			store_q <= 1'b0;
			ok_q    <= 1'b0;
		end else begin
			valid_q <= req_valid;
			store_q <= req_store;
			ok_q    <= acc_ok;
		end
	end

	always_ff @(posedge clk) begin
		size_q     <= acc_size;
		unsigned_q <= acc_unsigned;
		ofs_q      <= addr_low;
	end

	assign word_u    = doutb;
	assign byte_lane = word_u.bytes[ofs_q];
	assign half_lane = word_u.halves[ofs_q[OFS-1]]; // aligned, so top offset bit picks the half

	always_comb begin
		case (size_q)
			lsu_pkg::SIZE_BYTE:
				load_data = {{(lsu_pkg::WORD_WIDTH-8){byte_lane[7] & ~unsigned_q}}, byte_lane};
			lsu_pkg::SIZE_HALF:
				load_data = {{(lsu_pkg::WORD_WIDTH-16){half_lane[15] & ~unsigned_q}}, half_lane};
			default:
				load_data = word_u;
		endcase
	end

	// exactly one strobe per request
	assign load_valid = valid_q & ok_q & ~store_q;
	assign store_done = valid_q & ok_q & store_q;
	assign error      = valid_q & ~ok_q;

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/bin/sh
# build and run the lsu_mem testbench with Verilator
cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert --top-module lsu_mem_tb -f lsu_mem.f -Mdir obj_dir \
	&& ./obj_dir/Vlsu_mem_tb > "$log" 2>&1 \
	|| { echo "build or simulation failed"; cat "$log" 2>/dev/null; exit 1; }

cat "$log"

grep -q '^\*\* PASS \*\*$' "$log" \
	&& echo "simulation passed" \
	|| { echo "simulation failed"; exit 1; }

// ==== verif/lsu_mem_props.sv ====
`default_nettype none

// completion and write-enable rules on the LSU top level
module lsu_mem_props (
	input  logic       clk,
	input  logic       rst,
	input  logic       fetch_en,
	input  logic       fetch_valid,
	input  logic       req_valid,
	input  logic       req_store,
	input  logic [2:0] req_funct3,
	input  logic [1:0] addr_low,
	input  logic       web,
	input  logic       load_valid,
	input  logic       store_done,
	input  logic       error
);

	timeunit 1ns;
	timeprecision 1ps;

	logic bad_code;
	logic bad_store;
	logic bad_align;

	assign bad_code  = (req_funct3 == 3'd3) || (req_funct3[2:1] == 2'b11); // 3, 6, 7
	assign bad_store = req_store & req_funct3[2]; // no unsigned stores
	assign bad_align = (req_funct3[1:0] == 2'b01 && addr_low[0])
		|| (req_funct3[1:0] == 2'b10 && addr_low != 2'b00);

	one_completion: assert property (@(posedge clk) disable iff (rst)
		$onehot0({load_valid, store_done, error}))
		else $error("more than one completion strobe high");

	no_illegal_write: assert property (@(posedge clk) disable iff (rst)
		(req_valid && (bad_code || bad_store || bad_align)) |-> !web)
		else $error("RAM port B written by an illegal request");

	fetch_follows: assert property (@(posedge clk) disable iff (rst)
		fetch_valid == $past(fetch_en))
		else $error("fetch_valid does not follow fetch_en by one cycle");

endmodule

bind lsu_mem_top lsu_mem_props props_i (
	.clk         (clk),
	.rst         (rst),
	.fetch_en    (fetch_en),
	.fetch_valid (fetch_valid),
	.req_valid   (req_valid),
	.req_store   (req_store),
	.req_funct3  (req_funct3),
	.addr_low    (req_addr[1:0]),
	.web         (web),
	.load_valid  (load_valid),
	.store_done  (store_done),
	.error       (error)
);

`default_nettype wire

// ==== verif/lsu_mem_tb.sv ====
`default_nettype none

module lsu_mem_tb;

	timeunit 1ns;
	timeprecision 1ps;

	localparam int unsigned SIZE      = 64;
	localparam int unsigned MEM_BYTES = SIZE * lsu_pkg::WORD_BYTES;
	localparam int unsigned ABITS     = $clog2(MEM_BYTES);

	localparam logic [2:0] F3_B  = lsu_pkg::FUNCT3_B;
	localparam logic [2:0] F3_H  = lsu_pkg::FUNCT3_H;
	localparam logic [2:0] F3_W  = lsu_pkg::FUNCT3_W;
	localparam logic [2:0] F3_BU = lsu_pkg::FUNCT3_BU;
	localparam logic [2:0] F3_HU = lsu_pkg::FUNCT3_HU;

	typedef struct packed {
		logic        store;
		logic [2:0]  funct3;
		logic [31:0] addr;
		logic [31:0] wdata;
		logic        fetch_en;
		logic [31:0] fetch_addr;
	} entry_t;

	logic        clk = 1'b0;
	logic        rst;
	logic        fetch_en;
	logic [31:0] fetch_addr;
	logic        req_valid;
	logic        req_store;
	logic [2:0]  req_funct3;
	logic [31:0] req_addr;
	logic [31:0] req_wdata;
	logic        fetch_valid;
	logic [31:0] fetch_data;
	logic        load_valid;
	logic [31:0] load_data;
	logic        store_done;
	logic        error;

	entry_t      tests[$];
	string       names[$];
	logic [7:0]  model_mem [MEM_BYTES]; // byte-level reference memory
	int          seed = 32'h1972;
	bit          table_ready = 1'b0;

	lsu_mem_top #(.SIZE(SIZE)) dut_i (.*);

	always #10 clk = ~clk;

	task automatic add_entry(input string name, input logic store, input logic [2:0] funct3,
			input logic [31:0] addr, input logic [31:0] wdata,
			input logic fen, input logic [31:0] faddr);
		entry_t e;
		e = '{store, funct3, addr, wdata, fen, faddr};
		tests.push_back(e);
		names.push_back(name);
	endtask

	task automatic build_tests();
		logic [2:0] bad_codes [3] = '{3'd3, 3'd6, 3'd7};
		add_entry("sw_word", 1'b1, F3_W, 32'h10, $random(seed), 1'b0, 32'h0);
		add_entry("lw_word", 1'b0, F3_W, 32'h10, 32'h0, 1'b0, 32'h0);
		// byte stores over a known background, one lane at a time
		add_entry("sw_bg20", 1'b1, F3_W, 32'h20, 32'h0, 1'b0, 32'h0);
		add_entry("sw_bg24", 1'b1, F3_W, 32'h24, 32'hffff_ffff, 1'b0, 32'h0);
		for (int o = 0; o < 4; o++) begin
			add_entry($sformatf("sb_ofs%0d", o), 1'b1, F3_B, 32'h20 + o, $random(seed),
				1'b0, 32'h0);
			add_entry($sformatf("lw_after_sb%0d", o), 1'b0, F3_W, 32'h20, 32'h0, 1'b0, 32'h0);
		end
		for (int o = 0; o < 4; o += 2) begin
			add_entry($sformatf("sh_ofs%0d", o), 1'b1, F3_H, 32'h24 + o, $random(seed),
				1'b0, 32'h0);
			add_entry($sformatf("lw_after_sh%0d", o), 1'b0, F3_W, 32'h24, 32'h0, 1'b0, 32'h0);
		end
		// lanes with and without the sign bit set
		add_entry("sw_signs", 1'b1, F3_W, 32'h28, 32'h8001_7ff0, 1'b0, 32'h0);
		for (int base = 32'h20; base <= 32'h28; base += 8) begin
			for (int o = 0; o < 4; o++) begin
				add_entry($sformatf("lb_%0h", base + o), 1'b0, F3_B, base + o, 32'h0, 1'b0, 32'h0);
				add_entry($sformatf("lbu_%0h", base + o), 1'b0, F3_BU, base + o, 32'h0,
					1'b0, 32'h0);
			end
			for (int o = 0; o < 4; o += 2) begin
				add_entry($sformatf("lh_%0h", base + o), 1'b0, F3_H, base + o, 32'h0, 1'b0, 32'h0);
				add_entry($sformatf("lhu_%0h", base + o), 1'b0, F3_HU, base + o, 32'h0,
					1'b0, 32'h0);
			end
		end
		// rejected requests, none may touch word 0x28
		add_entry("lh_mis", 1'b0, F3_H, 32'h29, 32'h0, 1'b0, 32'h0);
		add_entry("lhu_mis", 1'b0, F3_HU, 32'h2b, 32'h0, 1'b0, 32'h0);
		add_entry("sh_mis", 1'b1, F3_H, 32'h2b, $random(seed), 1'b0, 32'h0);
		add_entry("lw_mis", 1'b0, F3_W, 32'h2a, 32'h0, 1'b0, 32'h0);
		add_entry("sw_mis1", 1'b1, F3_W, 32'h29, $random(seed), 1'b0, 32'h0);
		add_entry("sw_mis3", 1'b1, F3_W, 32'h2b, $random(seed), 1'b0, 32'h0);
		foreach (bad_codes[i]) begin
			add_entry($sformatf("ld_code%0d", bad_codes[i]), 1'b0, bad_codes[i], 32'h28, 32'h0,
				1'b0, 32'h0);
			add_entry($sformatf("st_code%0d", bad_codes[i]), 1'b1, bad_codes[i], 32'h28,
				$random(seed), 1'b0, 32'h0);
		end
		add_entry("sbu", 1'b1, F3_BU, 32'h28, $random(seed), 1'b0, 32'h0);
		add_entry("shu", 1'b1, F3_HU, 32'h28, $random(seed), 1'b0, 32'h0);
		add_entry("lw_untouched", 1'b0, F3_W, 32'h28, 32'h0, 1'b0, 32'h0);
		// fetches alongside back-to-back data requests on other words
		add_entry("sw_fetch30", 1'b1, F3_W, 32'h30, $random(seed), 1'b1, 32'h10);
		add_entry("sw_fetch34", 1'b1, F3_W, 32'h34, $random(seed), 1'b1, 32'h20);
		add_entry("lw_fetch", 1'b0, F3_W, 32'h30, 32'h0, 1'b1, 32'h24);
		add_entry("sb_fetch", 1'b1, F3_B, 32'h35, $random(seed), 1'b1, 32'h13);
		add_entry("lh_fetch", 1'b0, F3_H, 32'h34, 32'h0, 1'b1, 32'h30);
		add_entry("lbu_fetch", 1'b0, F3_BU, 32'h35, 32'h0, 1'b1, 32'h28);
		add_entry("lw_mis_fetch", 1'b0, F3_W, 32'h31, 32'h0, 1'b1, 32'h34);
	endtask

	function automatic bit request_legal(logic store, logic [2:0] funct3, logic [31:0] addr);
		case (funct3)
			F3_B:    return 1'b1;
			F3_BU:   return !store;
			F3_H:    return !addr[0];
			F3_HU:   return !store && !addr[0];
			F3_W:    return addr[1:0] == 2'b00;
			default: return 1'b0;
		endcase
	endfunction

	function automatic logic [31:0] word_at(logic [31:0] addr);
		logic [ABITS-1:0] a;
		a = {addr[ABITS-1:2], 2'b00};
		return {model_mem[a + 2'd3], model_mem[a + 2'd2], model_mem[a + 2'd1], model_mem[a]};
	endfunction

	function automatic logic [31:0] predict_load(logic [2:0] funct3, logic [31:0] addr);
		logic [ABITS-1:0] a;
		logic [7:0]       b;
		logic [15:0]      h;
		a = addr[ABITS-1:0];
		b = model_mem[a];
		h = {model_mem[a + 1'b1], model_mem[a]};
		case (funct3)
			F3_B:    return {{24{b[7]}}, b};
			F3_BU:   return {24'h0, b};
			F3_H:    return {{16{h[15]}}, h};
			F3_HU:   return {16'h0, h};
			default: return word_at(addr);
		endcase
	endfunction

	task automatic store_model(input logic [2:0] funct3, input logic [31:0] addr,
			input logic [31:0] wdata);
		logic [ABITS-1:0] a;
		a = addr[ABITS-1:0];
		model_mem[a] = wdata[7:0];
		if (funct3 != F3_B)
			model_mem[a + 1'b1] = wdata[15:8];
		if (funct3 == F3_W) begin
			model_mem[a + 2'd2] = wdata[23:16];
			model_mem[a + 2'd3] = wdata[31:24];
		end
	endtask

	task automatic fail_value(input string name, input string what,
			input logic [31:0] expected, input logic [31:0] actual);
		$display("** Error %s: %s expected %h, actual %h", name, what, expected, actual);
		$display("** FAIL **");
		$fatal(1, "stopping at first mismatch");
	endtask

	task automatic apply_entry(input entry_t e);
		req_valid  <= 1'b1;
		req_store  <= e.store;
		req_funct3 <= e.funct3;
		req_addr   <= e.addr;
		req_wdata  <= e.wdata;
		fetch_en   <= e.fetch_en;
		fetch_addr <= e.fetch_addr;
	endtask

	task automatic check_result(input string name, input entry_t e, input bit legal,
			input logic [31:0] exp_load, input logic [31:0] exp_fetch);
		logic [2:0] exp_strobes; // load, store, error
		exp_strobes = !legal ? 3'b001 : (e.store ? 3'b010 : 3'b100);
		assert ({load_valid, store_done, error} == exp_strobes)
			else fail_value(name, "strobes", 32'(exp_strobes),
				32'({load_valid, store_done, error}));
		if (legal && !e.store)
			assert (load_data == exp_load) else fail_value(name, "load_data", exp_load, load_data);
		assert (fetch_valid == e.fetch_en)
			else fail_value(name, "fetch_valid", 32'(e.fetch_en), 32'(fetch_valid));
		if (e.fetch_en)
			assert (fetch_data == exp_fetch)
				else fail_value(name, "fetch_data", exp_fetch, fetch_data);
	endtask

	initial begin
		entry_t      prev;
		string       prev_name;
		bit          have_prev;
		bit          prev_legal;
		logic [31:0] exp_load;
		logic [31:0] exp_fetch;

		// a live load and fetch while in reset, neither may complete
		rst        = 1'b1;
		fetch_en   = 1'b1;
		fetch_addr = 32'h0;
		req_valid  = 1'b1;
		req_store  = 1'b0;
		req_funct3 = F3_W;
		req_addr   = 32'h0;
		req_wdata  = 32'h0;
		have_prev  = 1'b0;
		build_tests();
		table_ready = 1'b1;

		repeat (3) @(posedge clk);
		fetch_en  <= 1'b0;
		req_valid <= 1'b0;
		@(negedge clk);
		assert ({fetch_valid, load_valid, store_done, error} == 4'b0000)
			else fail_value("reset", "strobes", 32'h0,
				32'({fetch_valid, load_valid, store_done, error}));
		assert (fetch_data == 32'h0)
			else fail_value("reset", "fetch_data", 32'h0, fetch_data);
		@(posedge clk);
		rst <= 1'b0;

		// results of entry k-1 are visible while entry k is being presented
		for (int k = 0; k <= tests.size(); k++) begin
			@(posedge clk);
			if (k < tests.size())
				apply_entry(tests[k]);
			else begin
				req_valid <= 1'b0;
				fetch_en  <= 1'b0;
			end
			@(negedge clk);
			if (have_prev)
				check_result(prev_name, prev, prev_legal, exp_load, exp_fetch);
			if (k < tests.size()) begin
				prev       = tests[k];
				prev_name  = names[k];
				prev_legal = request_legal(prev.store, prev.funct3, prev.addr);
				exp_load   = predict_load(prev.funct3, prev.addr);
				exp_fetch  = word_at(prev.fetch_addr);
				if (prev.store && prev_legal)
					store_model(prev.funct3, prev.addr, prev.wdata); // visible from next entry
				have_prev = 1'b1;
			end
		end

		$display("** PASS **");
		$finish;
	end

	// watchdog, scaled to the table length
	initial begin
		wait (table_ready);
		#((tests.size() + 4 + 20) * 20);
		$display("watchdog expired before the table finished");
		$display("** FAIL **");
		$fatal(1, "timeout");
	end

endmodule

`default_nettype wire
